/* common/bounce_pkg.sv */
// Shared types, playfield limits, bee table and display patterns, imported by the game RTL
package bounce_pkg;

    typedef logic [7:0]  x_t;
    typedef logic [6:0]  y_t;
    // Bit 3 left, bit 2 down, bit 1 up, bit 0 right
    typedef logic [3:0]  dir_t;
    typedef logic [1:0]  lives_t;
    typedef logic [7:0]  score_t;
    // Active low, bit 6 is segment g
    typedef logic [6:0]  seg_t;
    typedef logic [27:0] period_t;

    // Playfield borders
    localparam x_t x_right_limit  = 8'd152;
    localparam x_t x_left_limit   = 8'd4;
    localparam y_t y_bottom_limit = 7'd112;
    localparam y_t y_top_limit    = 7'd24;

    localparam x_t player_start_x = 8'd80;
    localparam y_t player_start_y = 7'd60;

    // Bee table
    localparam int num_bees = 6;
    localparam x_t bee_start_x [num_bees] = '{8'd30, 8'd34, 8'd103, 8'd67, 8'd108, 8'd67};
    localparam y_t bee_start_y [num_bees] = '{7'd48, 7'd74, 7'd89, 7'd100, 7'd56, 7'd29};
    localparam dir_t bee_start_dir [num_bees] =
        '{4'b1010, 4'b1100, 4'b0011, 4'b0101, 4'b0101, 4'b1100};
    // Contact distance on each axis
    localparam int bee_reach = 3;

    localparam lives_t lives_full = 2'd3;

    // Message shown on hex0 to hex7 at game over
    localparam seg_t over_pattern [8] = '{
        7'b0101111, 7'b0000110, 7'b1000001, 7'b1000000,
        7'b0000110, 7'b1101010, 7'b0001000, 7'b1000010
    };

    localparam seg_t seg_blank = 7'b1111111;

endpackage

/* rtl/game_timer.sv */
// Speed selection and the move and score tick strobes that pace the whole game
module game_timer
    import bounce_pkg::*;
#(
    parameter period_t base_period  = 28'd1000000,
    parameter period_t score_period = 28'd100000000
)
(
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic [1:0] speed_sel,
    output logic       move_tick,
    output logic       score_tick
);
    localparam period_t fast_period   = period_t'((base_period * 3) / 4);
    localparam period_t faster_period = period_t'(base_period / 2);

    period_t speed_q;
    period_t move_cnt;
    period_t score_cnt;

    // Speed switches are sampled every cycle
    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
            speed_q <= base_period;
        else
        begin
            case (speed_sel)
                2'b00:   speed_q <= base_period;
                2'b11:   speed_q <= faster_period;
                default: speed_q <= fast_period;
            endcase
        end
    end

    // Strobes fire on the reload cycle
    assign move_tick  = (move_cnt == '0);
    assign score_tick = (score_cnt == '0);

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            move_cnt  <= base_period - 1'b1;
            score_cnt <= score_period - 1'b1;
        end
        else
        begin
            move_cnt  <= move_tick ? speed_q - 1'b1 : move_cnt - 1'b1;
            score_cnt <= score_tick ? score_period - 1'b1 : score_cnt - 1'b1;
        end
    end

endmodule

/* sprites/sprite_motion.sv */
// Position register of one sprite, stepped one pixel per tick and reloadable to its start
module sprite_motion
    import bounce_pkg::*;
#(
    parameter x_t start_x = player_start_x,
    parameter y_t start_y = player_start_y
)
(
    input  logic CLOCK_50,
    input  logic reset,
    input  logic step,
    input  logic restart,
    input  dir_t dir,
    output x_t   x,
    output y_t   y
);
    x_t next_x;
    y_t next_y;

    // Right adds, left subtracts; down adds, up subtracts
    assign next_x = x + x_t'(dir[0]) - x_t'(dir[3]);
    assign next_y = y + y_t'(dir[2]) - y_t'(dir[1]);

    always_ff @(posedge CLOCK_50)
    begin
        if (reset || restart)
        begin
            x <= start_x;
            y <= start_y;
        end
        else if (step)
        begin
            x <= next_x;
            y <= next_y;
        end
    end

endmodule

/* sprites/bee_swarm.sv */
// The six bees with their bounce direction registers, all stepped on the common move tick
module bee_swarm
    import bounce_pkg::*;
(
    input  logic CLOCK_50,
    input  logic reset,
    input  logic move_tick,
    output x_t   bee_x [num_bees],
    output y_t   bee_y [num_bees]
);
    dir_t bee_dir [num_bees];

    for (genvar i = 0; i < num_bees; i++)
    begin : g_bee
        dir_t bounced;

        // Horizontal and vertical bounces are independent of each other
        always_comb
        begin
            bounced = bee_dir[i];
            if (bee_x[i] >= x_right_limit)
                bounced = {1'b1, bounced[2:1], 1'b0};
            else if (bee_x[i] <= x_left_limit)
                bounced = {1'b0, bounced[2:1], 1'b1};
            if (bee_y[i] == y_bottom_limit)
                bounced = {bounced[3], 2'b01, bounced[0]};
            else if (bee_y[i] == y_top_limit)
                bounced = {bounced[3], 2'b10, bounced[0]};
        end

        always_ff @(posedge CLOCK_50)
        begin
            if (reset)
                bee_dir[i] <= bee_start_dir[i];
            else if (move_tick)
                bee_dir[i] <= bounced;
        end

        // Motion uses the direction held before this tick's bounce
        sprite_motion #(
            .start_x (bee_start_x[i]),
            .start_y (bee_start_y[i])
        ) motion_i (
            .CLOCK_50 (CLOCK_50),
            .reset    (reset),
            .step     (move_tick),
            .restart  (1'b0),
            .dir      (bee_dir[i]),
            .x        (bee_x[i]),
            .y        (bee_y[i])
        );
    end

endmodule

/* game/hazard_detect.sv */
// Combinational check of the player against the playfield borders and the enabled bees
module hazard_detect
    import bounce_pkg::*;
(
    input  x_t                  player_x,
    input  y_t                  player_y,
    input  x_t                  bee_x [num_bees],
    input  y_t                  bee_y [num_bees],
    input  logic [num_bees-1:0] bee_enable,
    output logic                hit
);
    logic wall_hit;
    logic bee_hit;

    assign wall_hit = (player_x >= x_right_limit) || (player_x <= x_left_limit)
                   || (player_y >= y_bottom_limit) || (player_y <= y_top_limit);

    // Contact box of bee_reach pixels around each bee
    always_comb
    begin
        int dx;
        int dy;
        bee_hit = 1'b0;
        for (int i = 0; i < num_bees; i++)
        begin
            dx = int'(player_x) - int'(bee_x[i]);
            dy = int'(player_y) - int'(bee_y[i]);
            if (bee_enable[i] && dx >= -bee_reach && dx <= bee_reach
                    && dy >= -bee_reach && dy <= bee_reach)
                bee_hit = 1'b1;
        end
    end

    assign hit = wall_hit || bee_hit;

endmodule

/* game/life_keeper.sv */
// Player motion, lives, restart after a hit and the game-over latch with its switch acknowledge
module life_keeper
    import bounce_pkg::*;
(
    input  logic       CLOCK_50,
    input  logic       reset,
    input  logic       move_tick,
    input  logic       hit,
    input  logic [3:0] keys,
    input  logic       ack,
    output x_t         player_x,
    output y_t         player_y,
    output lives_t     lives,
    output logic       over,
    output logic       game_over_pulse
);
    dir_t player_dir;
    logic lose_life;
    logic ack_seen;

    // Keys are active low and map straight onto the direction bits
    assign player_dir = over ? dir_t'(0) : dir_t'(~keys);
    assign lose_life  = move_tick && hit && !over;

    sprite_motion #(
        .start_x (player_start_x),
        .start_y (player_start_y)
    ) player_i (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .step     (move_tick),
        .restart  (lose_life),
        .dir      (player_dir),
        .x        (player_x),
        .y        (player_y)
    );

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            lives           <= lives_full;
            over            <= 1'b0;
            ack_seen        <= 1'b0;
            game_over_pulse <= 1'b0;
        end
        else
        begin
            game_over_pulse <= 1'b0;
            if (lose_life)
            begin
                if (lives == '0)
                begin
                    // Out of lives
                    game_over_pulse <= 1'b1;
                    over            <= 1'b1;
                    ack_seen        <= 1'b0;
                    lives           <= lives_full;
                end
                else
                    lives <= lives - 1'b1;
            end
            else if (over && ack)
                ack_seen <= 1'b1;
            else if (ack_seen && !ack)
            begin
                // Switch went up and back down
                over     <= 1'b0;
                ack_seen <= 1'b0;
            end
        end
    end

endmodule

/* rtl/score_keeper.sv */
// Score counter paced by the score tick, and the high score register that tracks it
module score_keeper
    import bounce_pkg::*;
(
    input  logic   CLOCK_50,
    input  logic   reset,
    input  logic   score_tick,
    input  logic   over,
    input  logic   game_over_pulse,
    output score_t score,
    output score_t high_score
);

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            score      <= '0;
            high_score <= '0;
        end
        else
        begin
            if (game_over_pulse)
                score <= '0;
            else if (score_tick && !over)
                score <= score + 1'b1;   // wraps at 255

            // Follows the score a cycle behind
            if (score >= high_score)
                high_score <= score;
        end
    end

endmodule

/* rtl/status_display.sv */
// Seven-segment view of lives, score and high score, or the game-over message
module status_display
    import bounce_pkg::*;
(
    input  logic   over,
    input  lives_t lives,
    input  score_t score,
    input  score_t high_score,
    output seg_t   hex0,
    output seg_t   hex1,
    output seg_t   hex2,
    output seg_t   hex3,
    output seg_t   hex4,
    output seg_t   hex5,
    output seg_t   hex6,
    output seg_t   hex7
);

    // Hex digit to active low segments, g in bit 6
    function automatic seg_t hex_seg(input logic [3:0] value);
        case (value)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    always_comb
    begin
        if (over)
        begin
            hex0 = over_pattern[0];
            hex1 = over_pattern[1];
            hex2 = over_pattern[2];
            hex3 = over_pattern[3];
            hex4 = over_pattern[4];
            hex5 = over_pattern[5];
            hex6 = over_pattern[6];
            hex7 = over_pattern[7];
        end
        else
        begin
            hex0 = hex_seg({2'b00, lives});
            hex1 = seg_blank;
            hex2 = seg_blank;
            hex3 = seg_blank;
            hex4 = hex_seg(score[3:0]);
            hex5 = hex_seg(score[7:4]);
            hex6 = hex_seg(high_score[3:0]);
            hex7 = hex_seg(high_score[7:4]);
        end
    end

endmodule

/* rtl/bounce_top.sv */
// Top level of the bee-dodging game, wiring the game blocks to switches, keys, LEDs and displays
module bounce_top
    import bounce_pkg::*;
#(
    parameter period_t base_period  = 28'd1000000,
    parameter period_t score_period = 28'd100000000
)
(
    input  logic        CLOCK_50,
    input  logic        reset,
    input  logic [17:0] sw,
    input  logic [3:0]  key,
    output logic [17:0] ledr,
    output seg_t        hex0,
    output seg_t        hex1,
    output seg_t        hex2,
    output seg_t        hex3,
    output seg_t        hex4,
    output seg_t        hex5,
    output seg_t        hex6,
    output seg_t        hex7
);
    logic   move_tick;
    logic   score_tick;
    x_t     bee_x [num_bees];
    y_t     bee_y [num_bees];
    x_t     player_x;
    y_t     player_y;
    logic   hit;
    lives_t lives;
    logic   over;
    logic   game_over_pulse;
    score_t score;
    score_t high_score;

    // sw[17:16] pick the game speed
    game_timer #(
        .base_period  (base_period),
        .score_period (score_period)
    ) timer_i (
        .CLOCK_50   (CLOCK_50),
        .reset      (reset),
        .speed_sel  (sw[17:16]),
        .move_tick  (move_tick),
        .score_tick (score_tick)
    );

    bee_swarm bees_i (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .move_tick (move_tick),
        .bee_x     (bee_x),
        .bee_y     (bee_y)
    );

    // sw[5:0] enable the bees one by one
    hazard_detect hazard_i (
        .player_x   (player_x),
        .player_y   (player_y),
        .bee_x      (bee_x),
        .bee_y      (bee_y),
        .bee_enable (sw[5:0]),
        .hit        (hit)
    );

    // sw[15] acknowledges game over
    life_keeper lives_i (
        .CLOCK_50        (CLOCK_50),
        .reset           (reset),
        .move_tick       (move_tick),
        .hit             (hit),
        .keys            (key),
        .ack             (sw[15]),
        .player_x        (player_x),
        .player_y        (player_y),
        .lives           (lives),
        .over            (over),
        .game_over_pulse (game_over_pulse)
    );

    score_keeper score_i (
        .CLOCK_50        (CLOCK_50),
        .reset           (reset),
        .score_tick      (score_tick),
        .over            (over),
        .game_over_pulse (game_over_pulse),
        .score           (score),
        .high_score      (high_score)
    );

    status_display display_i (
        .over       (over),
        .lives      (lives),
        .score      (score),
        .high_score (high_score),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5),
        .hex6       (hex6),
        .hex7       (hex7)
    );

    // Only ledr[15] is lit, during game over
    assign ledr = {2'b00, over, 15'd0};

endmodule

/* test/bounce_asserts.sv */
// Concurrent checks on the board ports of the game, bound into the top level by the testbench
module bounce_asserts
    import bounce_pkg::*;
#(
    parameter int score_interval = 400
)
(
    input logic        CLOCK_50,
    input logic        reset,
    input logic [17:0] sw,
    input logic [3:0]  key,
    input logic [17:0] ledr,
    input seg_t        hex0,
    input seg_t        hex1,
    input seg_t        hex2,
    input seg_t        hex3,
    input seg_t        hex4,
    input seg_t        hex5,
    input seg_t        hex6,
    input seg_t        hex7
);
    timeunit 1ns;
    timeprecision 100ps;

    // Active low patterns of the hex digits 0 to f
    localparam seg_t digit_seg [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    int   failures = 0;
    int   cycle_count;
    int   hs_keep;
    int   lives_val;
    int   score_val;
    int   hs_val;
    logic idle_run;
    logic ack_high;
    logic over;
    logic msg_shown;

    // Unknown patterns give a value far outside any count
    function automatic int digit_of(input seg_t seg);
        for (int i = 0; i < 16; i++)
        begin
            if (digit_seg[i] == seg)
                return i;
        end
        return -1000;
    endfunction

    assign over      = ledr[15];
    assign lives_val = digit_of(hex0);
    assign score_val = digit_of(hex5) * 16 + digit_of(hex4);
    assign hs_val    = digit_of(hex7) * 16 + digit_of(hex6);
    assign msg_shown = hex0 == over_pattern[0] && hex1 == over_pattern[1]
                    && hex2 == over_pattern[2] && hex3 == over_pattern[3]
                    && hex4 == over_pattern[4] && hex5 == over_pattern[5]
                    && hex6 == over_pattern[6] && hex7 == over_pattern[7];

    always_ff @(posedge CLOCK_50)
    begin
        if (reset)
        begin
            cycle_count <= 0;
            hs_keep     <= 0;
            idle_run    <= 1'b1;
            ack_high    <= 1'b0;
        end
        else
        begin
            cycle_count <= cycle_count + 1;
            // Any key or enabled bee ends the idle stretch
            if (sw[5:0] != 6'd0 || key != 4'hf)
                idle_run <= 1'b0;
            if (!over)
                ack_high <= 1'b0;
            else if (sw[15])
                ack_high <= 1'b1;
            if (!over)
                hs_keep <= (score_val > hs_val) ? score_val : hs_val;
        end
    end

    // One step up at each interval, no change in between
    score_step: assert property (@(posedge CLOCK_50) disable iff (reset)
        !over && !$past(over) && !$past(reset)
            |-> score_val == ((cycle_count % score_interval == 0)
                              ? ($past(score_val) + 1) % 256 : $past(score_val)))
        else begin failures++; $error("score changed off its interval or not by one"); end

    high_score_follows: assert property (@(posedge CLOCK_50) disable iff (reset)
        !over && !$past(over) && !$past(reset) |-> hs_val >= $past(score_val))
        else begin failures++; $error("high score fell below the score"); end

    lives_step: assert property (@(posedge CLOCK_50) disable iff (reset)
        !over && !$past(over) && !$past(reset) && lives_val != $past(lives_val)
            |-> lives_val == $past(lives_val) - 1)
        else begin failures++; $error("lives digit changed by other than one down"); end

    over_entry: assert property (@(posedge CLOCK_50) disable iff (reset)
        $rose(over) && !$past(reset) |-> $past(lives_val) == 0)
        else begin failures++; $error("game over came with lives left"); end

    over_message: assert property (@(posedge CLOCK_50) disable iff (reset)
        over |-> msg_shown)
        else begin failures++; $error("displays do not show the game over message"); end

    over_exit: assert property (@(posedge CLOCK_50) disable iff (reset)
        $fell(over) && !$past(reset)
            |-> ack_high && !$past(sw[15]) && lives_val == 3 && score_val == 0
                && hs_val >= hs_keep)
        else begin failures++; $error("game over cleared in a wrong way or state"); end

    unused_leds: assert property (@(posedge CLOCK_50) disable iff (reset)
        ledr[17:16] == 2'b00 && ledr[14:0] == 15'd0)
        else begin failures++; $error("a red LED other than 15 is lit"); end

    idle_safe: assert property (@(posedge CLOCK_50) disable iff (reset)
        idle_run && !$past(reset) |-> lives_val == 3 && !over)
        else begin failures++; $error("a life was lost with no key and no bee enabled"); end

endmodule

/* test/bounce_tb.sv */
// Testbench of the game top level, walking it through idle, bee, wall, game over and speed runs
module bounce_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int         reset_cycles = 16;
    localparam logic [6:0] blank_exp    = 7'h7f;
    // Active low patterns of the digits 0 to 3
    localparam logic [6:0] digit_exp [4] = '{7'h40, 7'h79, 7'h24, 7'h30};

    logic        CLOCK_50;
    logic        reset;
    logic [17:0] sw;
    logic [3:0]  key;
    logic [17:0] ledr;
    logic [6:0]  hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    logic [31:0] lfsr;
    logic [1:0]  key_idx;
    int          cycles;
    int          slow_cycles;
    int          fast_cycles;

    bounce_top #(
        .base_period  (40),
        .score_period (400)
    ) dut_i (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .sw       (sw),
        .key      (key),
        .ledr     (ledr),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .hex6     (hex6),
        .hex7     (hex7)
    );

    bind bounce_top bounce_asserts asserts_i (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .sw       (sw),
        .key      (key),
        .ledr     (ledr),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .hex6     (hex6),
        .hex7     (hex7)
    );

    initial
    begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic random_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    task automatic stop_with(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic next_cycle();
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (reset_cycles) next_cycle();
        reset = 1'b0;
    endtask

    task automatic check_value(input string test, input logic [6:0] expected,
                               input logic [6:0] actual);
        if (actual !== expected)
            stop_with($sformatf("error: %s expected %h actual %h", test, expected, actual));
    endtask

    task automatic wait_lives_change(input string test, input int limit, output int count);
        logic [6:0] start;
        start = hex0;
        count = 0;
        while (hex0 === start)
        begin
            if (count >= limit)
                stop_with($sformatf("%s timed out, lives digit did not change in %0d cycles",
                                    test, limit));
            next_cycle();
            count++;
        end
    endtask

    task automatic wait_game_over(input string test, input logic level, input int limit);
        int count;
        count = 0;
        while (ledr[15] !== level)
        begin
            if (count >= limit)
                stop_with($sformatf("%s timed out, game over LED did not reach %b", test, level));
            next_cycle();
            count++;
        end
    endtask

    // Failures from the bound checker end the run at once
    always @(posedge CLOCK_50)
    begin
        if (dut_i.asserts_i.failures != 0)
            stop_with("an assertion in the bound checker failed");
    end

    initial
    begin
        reset = 1'b1;
        sw    = '0;
        key   = 4'hf;
        lfsr  = 32'h16d0330c;
        apply_reset();

        check_value("reset lives", digit_exp[3], hex0);
        check_value("reset hex1", blank_exp, hex1);
        check_value("reset hex2", blank_exp, hex2);
        check_value("reset hex3", blank_exp, hex3);
        check_value("reset score low", digit_exp[0], hex4);
        check_value("reset score high", digit_exp[0], hex5);
        check_value("reset high score low", digit_exp[0], hex6);
        check_value("reset high score high", digit_exp[0], hex7);
        check_value("reset game over led", 7'h00, {6'b0, ledr[15]});

        // Player parked at the start with the bees off
        for (int i = 0; i < 2000; i++)
        begin
            next_cycle();
            check_value("idle lives", digit_exp[3], hex0);
        end

        sw[5:0] = 6'h3f;
        wait_lives_change("bee contact", 200000, cycles);
        sw[5:0] = 6'h00;

        // Random key and speed for the wall run
        key_idx[1] = random_bit();
        key_idx[0] = random_bit();
        sw[17]     = random_bit();
        sw[16]     = random_bit();
        key        = ~(4'b0001 << key_idx);
        apply_reset();
        for (int d = 2; d >= 0; d--)
        begin
            wait_lives_change("wall hit", 10000, cycles);
            check_value("wall hit lives", digit_exp[d], hex0);
        end
        wait_game_over("game over set", 1'b1, 10000);
        key = 4'hf;
        repeat (1000) next_cycle();
        sw[15] = 1'b1;
        repeat (4) next_cycle();
        sw[15] = 1'b0;
        wait_game_over("game over acknowledge", 1'b0, 100);
        check_value("restart lives", digit_exp[3], hex0);
        check_value("restart score low", digit_exp[0], hex4);
        check_value("restart score high", digit_exp[0], hex5);

        // Same key at the slowest and the fastest speed
        key       = ~(4'b0001 << key_idx);
        sw[17:16] = 2'b00;
        apply_reset();
        wait_lives_change("speed 00", 10000, slow_cycles);
        sw[17:16] = 2'b11;
        apply_reset();
        wait_lives_change("speed 11", 10000, fast_cycles);
        if (fast_cycles > slow_cycles)
            stop_with($sformatf("error: speed compare expected at most %0d actual %0d",
                                slow_cycles, fast_cycles));

        if (dut_i.asserts_i.failures == 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
            stop_with("assertion failures were counted by the bound checker");
    end

endmodule

/* project.f */
common/bounce_pkg.sv
rtl/game_timer.sv
sprites/sprite_motion.sv
sprites/bee_swarm.sv
game/hazard_detect.sv
game/life_keeper.sv
rtl/score_keeper.sv
rtl/status_display.sv
rtl/bounce_top.sv
test/bounce_asserts.sv
test/bounce_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = bounce_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "Result: passed" || (echo "Result: failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
